/* logic/fetch_pkg.sv */
// Shared address map and fetch attribute types, imported by the fetch stage RTL
package fetch_pkg;

    ////////////////////
    // Address map

    // Local instruction RAM starts here, size set by RAM_WORDS
    localparam logic [31:0] LOCAL_BASE = 32'h0000_0000;

    // External bus window, both bounds inclusive
    localparam logic [31:0] BUS_BASE  = 32'h8000_0000;
    localparam logic [31:0] BUS_LIMIT = 32'h8000_FFFF;

    ////////////////////
    // Types

    // Which sub-unit serves a request
    typedef enum logic {
        UNIT_LOCAL = 1'b0,
        UNIT_BUS   = 1'b1
    } unit_id_t;

    // Per-request record kept in the in-flight FIFO
    typedef struct packed {
        logic [31:0] pc;
        unit_id_t    unit;
        logic        fault;  // unmapped address
    } fetch_attr_t;

endpackage

/* logic/fetch_ifs.sv */
// Interfaces between the fetch unit, its sub-units, the RAM arbiter and the RAM
`timescale 1ns/1ps

// Fetch unit to one fetch sub-unit
interface fetch_sub_if;
    logic        req;
    logic [31:0] addr;
    logic        ready;
    logic        data_valid;
    logic [31:0] data;
    logic        take;

    modport requester (
        output req, addr, take,
        input  ready, data_valid, data
    );

    modport responder (
        input  req, addr, take,
        output ready, data_valid, data
    );
endinterface

// One port of the single-ported instruction RAM
interface ram_port_if #(
    parameter int ADDR_W = 10
);
    logic              valid;
    logic              ready;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       wdata;
    logic [31:0]       rdata;

    modport requester (output valid, we, addr, wdata, input ready, rdata);
    modport arbiter (input valid, we, addr, wdata, output ready, rdata);
    modport memory (input valid, we, addr, wdata, output ready, rdata);
endinterface

/* logic/attr_fifo.sv */
// In-order register FIFO holding the attributes of each fetch request in flight
`timescale 1ns/1ps

module attr_fifo #(
    parameter int MAX_INFLIGHT = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  fetch_pkg::fetch_attr_t data_in,
    input  logic                   pop,
    output fetch_pkg::fetch_attr_t data_out,
    output logic                   valid,
    output logic                   full
);
    import fetch_pkg::*;

    localparam int PTR_W = (MAX_INFLIGHT > 1) ? $clog2(MAX_INFLIGHT) : 1;
    localparam int CNT_W = $clog2(MAX_INFLIGHT + 1);

    fetch_attr_t        entries [MAX_INFLIGHT];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(MAX_INFLIGHT - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(MAX_INFLIGHT - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= data_in;
    end

    assign data_out = entries[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(MAX_INFLIGHT));

    push_not_full_a: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("attr_fifo push while full");
    pop_not_empty_a: assert property (@(posedge clk) disable iff (rst) pop |-> valid)
        else $error("attr_fifo pop while empty");

endmodule

/* logic/inst_ram.sv */
// Single-port instruction RAM, word addressed, with a registered read
`timescale 1ns/1ps

module inst_ram #(
    parameter int RAM_WORDS = 1024
) (
    input logic        clk,
    ram_port_if.memory port
);
    logic [31:0] mem [RAM_WORDS];

    // Writes never stall
    assign port.ready = 1'b1;

    always_ff @(posedge clk) begin
        if (port.valid && port.we)
            mem[port.addr] <= port.wdata;
    end

    // Read data appears the cycle after the transfer
    always_ff @(posedge clk) begin
        if (port.valid && !port.we)
            port.rdata <= mem[port.addr];
    end

endmodule

/* logic/ram_arbiter.sv */
// Fixed-priority arbiter sharing the instruction RAM between loader and local fetch
`timescale 1ns/1ps

module ram_arbiter (
    input logic         clk,
    input logic         rst,
    ram_port_if.arbiter loader,
    ram_port_if.arbiter fetch,
    ram_port_if.requester ram
);
    logic loader_gnt;

    ////////////////////
    // Grant

    // Loader wins whenever it asks
    assign loader_gnt = loader.valid;

    assign ram.valid = loader.valid | fetch.valid;
    assign ram.we    = loader_gnt ? loader.we    : fetch.we;
    assign ram.addr  = loader_gnt ? loader.addr  : fetch.addr;
    assign ram.wdata = loader_gnt ? loader.wdata : fetch.wdata;

    assign loader.ready = ram.ready;
    assign fetch.ready  = ram.ready & ~loader_gnt;

    ////////////////////
    // Read return

    // Only the fetch side reads
    assign fetch.rdata  = ram.rdata;
    assign loader.rdata = '0;

    // A stalled fetch read must wait with the same address
    fetch_hold_a: assert property (@(posedge clk) disable iff (rst)
        fetch.valid && !fetch.ready |=> fetch.valid && $stable(fetch.addr))
        else $error("fetch read dropped while waiting for grant");

endmodule

/* logic/local_mem_unit.sv */
// Fetch sub-unit reading the local instruction RAM and holding the word until taken
`timescale 1ns/1ps

module local_mem_unit #(
    parameter int RAM_WORDS = 1024
) (
    input logic           clk,
    input logic           rst,
    fetch_sub_if.responder sub,
    ram_port_if.requester  ram
);
    import fetch_pkg::*;

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   offset;
    logic [AW-1:0] word_idx;
    logic [AW-1:0] addr_q;
    logic [31:0]   data_q;
    logic          pending;
    logic          rd_wait;
    logic          have_data;
    logic          accept;
    logic          ram_xfer;

    assign offset   = sub.addr - LOCAL_BASE;
    assign word_idx = offset[AW+1:2];

    // Idle only, one request at a time
    assign sub.ready = ~pending & ~rd_wait & ~have_data;
    assign accept    = sub.req & sub.ready;

    // Read goes out in the accept cycle, or later if the loader holds the port
    assign ram.valid = accept | pending;
    assign ram.we    = 1'b0;
    assign ram.addr  = pending ? addr_q : word_idx;
    assign ram.wdata = '0;
    assign ram_xfer  = ram.valid & ram.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            rd_wait   <= 1'b0;
            have_data <= 1'b0;
        end else begin
            rd_wait <= ram_xfer;
            if (ram_xfer)
                pending <= 1'b0;
            else if (accept)
                pending <= 1'b1;
            if (rd_wait)
                have_data <= 1'b1;
            else if (sub.take)
                have_data <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            addr_q <= word_idx;
        if (rd_wait)
            data_q <= ram.rdata;
    end

    assign sub.data_valid = have_data;
    assign sub.data       = data_q;

endmodule

/* logic/bus_unit.sv */
// Fetch sub-unit issuing reads on the external instruction bus, variable latency
`timescale 1ns/1ps

module bus_unit (
    input  logic           clk,
    input  logic           rst,
    fetch_sub_if.responder sub,
    output logic           ibus_req_valid,
    input  logic           ibus_req_ready,
    output logic [31:0]    ibus_req_addr,
    input  logic           ibus_resp_valid,
    input  logic [31:0]    ibus_resp_data
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_RESP
    } state_t;

    state_t      state;
    logic [31:0] addr_q;
    logic [31:0] data_q;
    logic        have_data;

    assign sub.ready = (state == S_IDLE) & ~have_data;

    ////////////////////
    // Controller

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            have_data <= 1'b0;
        end else begin
            case (state)
                S_IDLE:
                    if (sub.req && sub.ready)
                        state <= S_REQ;
                S_REQ:
                    if (ibus_req_ready)
                        state <= S_RESP;
                S_RESP:
                    if (ibus_resp_valid)
                        state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
            // Word waits here for the fetch unit
            if (state == S_RESP && ibus_resp_valid)
                have_data <= 1'b1;
            else if (sub.take)
                have_data <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sub.req && sub.ready)
            addr_q <= sub.addr;
        if (state == S_RESP && ibus_resp_valid)
            data_q <= ibus_resp_data;
    end

    assign ibus_req_valid = (state == S_REQ);
    assign ibus_req_addr  = addr_q;
    assign sub.data_valid = have_data;
    assign sub.data       = data_q;

    no_idle_resp_a: assert property (@(posedge clk) disable iff (rst)
        state == S_IDLE |-> !ibus_resp_valid)
        else $error("ibus response with no request outstanding");

endmodule

/* logic/fetch_unit.sv */
// Fetch control: PC, request issue by region, in-flight tracking and in-order return
`timescale 1ns/1ps

module fetch_unit #(
    parameter int          RAM_WORDS    = 1024,
    parameter logic [31:0] RESET_PC     = 32'h0,
    parameter int          MAX_INFLIGHT = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        fetch_ready,
    fetch_sub_if.requester local_sub,
    fetch_sub_if.requester bus_sub,
    output logic        fetch_valid,
    output logic [31:0] fetch_pc,
    output logic [31:0] fetch_instr,
    output logic        fetch_fault
);
    import fetch_pkg::*;

    localparam int CNT_W = $clog2(MAX_INFLIGHT + 1);

    logic [31:0]      pc;
    logic [31:0]      pc_off;
    logic             is_local;
    logic             is_bus;
    logic             unmapped;
    unit_id_t         target;
    unit_id_t         last_unit;
    logic             order_ok;
    logic             unit_ready;
    logic             issue;
    logic             fault_hold;
    fetch_attr_t      fifo_in;
    fetch_attr_t      head;
    logic             fifo_valid;
    logic             fifo_full;
    logic             pop;
    logic             head_is_bus;
    logic             head_done;
    logic             discarding;
    logic [CNT_W-1:0] inflight_cnt;
    logic [CNT_W-1:0] inflight_next;
    logic [CNT_W-1:0] discard_cnt;

    ////////////////////
    // Issue

    assign pc_off   = pc - LOCAL_BASE;
    assign is_local = pc_off < 32'(RAM_WORDS * 4);
    assign is_bus   = (pc >= BUS_BASE) && (pc <= BUS_LIMIT);
    assign unmapped = ~is_local & ~is_bus;
    assign target   = is_bus ? UNIT_BUS : UNIT_LOCAL;

    // Never mix units in flight, keeps results in request order
    assign order_ok   = (inflight_cnt == '0) | (last_unit == target);
    assign unit_ready = is_bus ? bus_sub.ready : local_sub.ready;
    assign issue      = ~fault_hold & ~redirect_valid & ~fifo_full
                        & (unmapped | (unit_ready & order_ok));

    assign local_sub.req  = issue & is_local;
    assign local_sub.addr = pc;
    assign bus_sub.req    = issue & is_bus;
    assign bus_sub.addr   = pc;

    assign fifo_in = '{pc: pc, unit: target, fault: unmapped};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= RESET_PC;
            fault_hold <= 1'b0;
            last_unit  <= UNIT_LOCAL;
        end else begin
            if (redirect_valid)
                pc <= {redirect_pc[31:2], 2'b00};
            else if (issue && !unmapped)
                pc <= pc + 32'd4;
            // Stop after a fault until the next redirect
            if (redirect_valid)
                fault_hold <= 1'b0;
            else if (issue && unmapped)
                fault_hold <= 1'b1;
            if (issue && !unmapped)
                last_unit <= target;
        end
    end

    attr_fifo #(
        .MAX_INFLIGHT(MAX_INFLIGHT)
    ) attr_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (issue),
        .data_in  (fifo_in),
        .pop      (pop),
        .data_out (head),
        .valid    (fifo_valid),
        .full     (fifo_full)
    );

    ////////////////////
    // Result return

    assign head_is_bus = (head.unit == UNIT_BUS);
    assign head_done   = fifo_valid & (head.fault
                         | (head_is_bus ? bus_sub.data_valid : local_sub.data_valid));
    assign discarding  = (discard_cnt != '0);

    assign fetch_valid = head_done & ~discarding & ~redirect_valid;
    assign pop         = head_done & (discarding | (fetch_ready & ~redirect_valid));
    assign fetch_pc    = head.pc;
    assign fetch_fault = head.fault;
    assign fetch_instr = head.fault ? 32'h0 : (head_is_bus ? bus_sub.data : local_sub.data);

    assign local_sub.take = pop & ~head.fault & ~head_is_bus;
    assign bus_sub.take   = pop & ~head.fault & head_is_bus;

    ////////////////////
    // In-flight and flush counting

    assign inflight_next = inflight_cnt + CNT_W'(issue) - CNT_W'(pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_cnt <= '0;
            discard_cnt  <= '0;
        end else begin
            inflight_cnt <= inflight_next;
            // Everything older than the redirect gets dropped
            if (redirect_valid)
                discard_cnt <= inflight_next;
            else if (pop && discarding)
                discard_cnt <= discard_cnt - 1'b1;
        end
    end

    local_order_a: assert property (@(posedge clk) disable iff (rst)
        local_sub.data_valid |-> fifo_valid && !head.fault && head.unit == UNIT_LOCAL)
        else $error("local result with another entry at FIFO head");
    bus_order_a: assert property (@(posedge clk) disable iff (rst)
        bus_sub.data_valid |-> fifo_valid && !head.fault && head.unit == UNIT_BUS)
        else $error("bus result with another entry at FIFO head");

endmodule

/* logic/fetch_top.sv */
// Fetch stage top level, joins fetch unit, sub-units, RAM arbiter and instruction RAM
`timescale 1ns/1ps

module fetch_top #(
    parameter int          RAM_WORDS    = 1024,
    parameter logic [31:0] RESET_PC     = 32'h0,
    parameter int          MAX_INFLIGHT = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    // Loader writes
    input  logic                         load_valid,
    output logic                         load_ready,
    input  logic [$clog2(RAM_WORDS)-1:0] load_addr,
    input  logic [31:0]                  load_data,
    // External instruction bus
    output logic                         ibus_req_valid,
    input  logic                         ibus_req_ready,
    output logic [31:0]                  ibus_req_addr,
    input  logic                         ibus_resp_valid,
    input  logic [31:0]                  ibus_resp_data,
    // Redirect
    input  logic                         redirect_valid,
    input  logic [31:0]                  redirect_pc,
    // Decode side
    output logic                         fetch_valid,
    input  logic                         fetch_ready,
    output logic [31:0]                  fetch_pc,
    output logic [31:0]                  fetch_instr,
    output logic                         fetch_fault
);
    localparam int RAM_AW = $clog2(RAM_WORDS);

    fetch_sub_if                      local_sub_if ();
    fetch_sub_if                      bus_sub_if ();
    ram_port_if #(.ADDR_W(RAM_AW))    loader_port ();
    ram_port_if #(.ADDR_W(RAM_AW))    fetch_port ();
    ram_port_if #(.ADDR_W(RAM_AW))    mem_port ();

    // Loader is write only
    assign loader_port.valid = load_valid;
    assign loader_port.we    = 1'b1;
    assign loader_port.addr  = load_addr;
    assign loader_port.wdata = load_data;
    assign load_ready        = loader_port.ready;

    fetch_unit #(
        .RAM_WORDS    (RAM_WORDS),
        .RESET_PC     (RESET_PC),
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) fetch_unit_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_ready    (fetch_ready),
        .local_sub      (local_sub_if.requester),
        .bus_sub        (bus_sub_if.requester),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_instr    (fetch_instr),
        .fetch_fault    (fetch_fault)
    );

    local_mem_unit #(
        .RAM_WORDS (RAM_WORDS)
    ) local_mem_unit_i (
        .clk (clk),
        .rst (rst),
        .sub (local_sub_if.responder),
        .ram (fetch_port.requester)
    );

    bus_unit bus_unit_i (
        .clk             (clk),
        .rst             (rst),
        .sub             (bus_sub_if.responder),
        .ibus_req_valid  (ibus_req_valid),
        .ibus_req_ready  (ibus_req_ready),
        .ibus_req_addr   (ibus_req_addr),
        .ibus_resp_valid (ibus_resp_valid),
        .ibus_resp_data  (ibus_resp_data)
    );

    ram_arbiter ram_arbiter_i (
        .clk    (clk),
        .rst    (rst),
        .loader (loader_port.arbiter),
        .fetch  (fetch_port.arbiter),
        .ram    (mem_port.requester)
    );

    inst_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) inst_ram_i (
        .clk  (clk),
        .port (mem_port.memory)
    );

endmodule

/* verif/fetch_tb_ref.svh */
// Reference model for the fetch testbench, included inside the testbench module body
`ifndef FETCH_TB_REF_SVH
`define FETCH_TB_REF_SVH

// External bus window, both bounds inclusive
localparam logic [31:0] REF_BUS_BASE  = 32'h8000_0000;
localparam logic [31:0] REF_BUS_LIMIT = 32'h8000_FFFF;

// Word the bus model returns for an address
function automatic logic [31:0] ref_bus_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
endfunction

// Local RAM covers RAM_WORDS words from address zero
function automatic logic ref_is_local(input logic [31:0] pc);
    return pc < 32'(RAM_WORDS * 4);
endfunction

function automatic logic ref_is_bus(input logic [31:0] pc);
    return (pc >= REF_BUS_BASE) && (pc <= REF_BUS_LIMIT);
endfunction

// Expected {fault, instr} for a fetch at pc
function automatic logic [32:0] ref_expect(input logic [31:0] pc);
    logic [32:0] res;
    if (ref_is_local(pc))
        res = {1'b0, mirror[pc[AW+1:2]]};
    else if (ref_is_bus(pc))
        res = {1'b0, ref_bus_word(pc)};
    else
        // Unmapped, no word comes back
        res = {1'b1, 32'h0};
    return res;
endfunction

`endif

/* verif/fetch_tb.sv */
// Testbench for the fetch stage, drives loader, bus and redirects and checks results in order
`timescale 1ns/1ps

module fetch_tb;

    localparam int          RAM_WORDS       = 1024;
    localparam int          AW              = $clog2(RAM_WORDS);
    localparam logic [31:0] RESET_PC        = 32'h0;
    localparam int          MAX_INFLIGHT    = 2;
    localparam int          WAIT_PER_RESULT = 40;
    // Results expected over all six tests
    localparam int          TOTAL_RESULTS   = 64 + 32 + 9 + 48 + 96 + 16;
    localparam int          WATCHDOG_CYCLES = WAIT_PER_RESULT * TOTAL_RESULTS + 200;

    logic          clk;
    logic          rst;
    logic          load_valid;
    logic          load_ready;
    logic [AW-1:0] load_addr;
    logic [31:0]   load_data;
    logic          ibus_req_valid;
    logic          ibus_req_ready;
    logic [31:0]   ibus_req_addr;
    logic          ibus_resp_valid;
    logic [31:0]   ibus_resp_data;
    logic          redirect_valid;
    logic [31:0]   redirect_pc;
    logic          fetch_valid;
    logic          fetch_ready;
    logic [31:0]   fetch_pc;
    logic [31:0]   fetch_instr;
    logic          fetch_fault;

    // Copy of what the loader wrote
    logic [31:0]   mirror [RAM_WORDS];
    integer        seed;
    int            errors;
    int            checks;
    int            tests_run;
    int            errors_at_start;
    int            got_n;
    int            expect_n;
    logic [31:0]   exp_pc;
    logic          hold_seen;
    logic [31:0]   held_pc;
    logic [31:0]   held_instr;

    `include "fetch_tb_ref.svh"

    fetch_top #(
        .RAM_WORDS    (RAM_WORDS),
        .RESET_PC     (RESET_PC),
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) dut_i (
        .clk             (clk),
        .rst             (rst),
        .load_valid      (load_valid),
        .load_ready      (load_ready),
        .load_addr       (load_addr),
        .load_data       (load_data),
        .ibus_req_valid  (ibus_req_valid),
        .ibus_req_ready  (ibus_req_ready),
        .ibus_req_addr   (ibus_req_addr),
        .ibus_resp_valid (ibus_resp_valid),
        .ibus_resp_data  (ibus_resp_data),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .fetch_valid     (fetch_valid),
        .fetch_ready     (fetch_ready),
        .fetch_pc        (fetch_pc),
        .fetch_instr     (fetch_instr),
        .fetch_fault     (fetch_fault)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // Helpers

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic load_block(input int base, input int n, input int max_gap);
        logic [31:0] word;
        int          k;
        int          wait_n;
        for (k = 0; k < n; k++) begin
            word       = $random(seed);
            load_valid = 1'b1;
            load_addr  = AW'(base + k);
            load_data  = word;
            wait_n     = 0;
            while (load_ready !== 1'b1 && wait_n < 20) begin
                next_cycle();
                wait_n++;
            end
            if (load_ready !== 1'b1) begin
                errors++;
                $display("loader write to word %0d was never accepted", base + k);
            end else begin
                mirror[base + k] = word;
            end
            next_cycle();
            load_valid = 1'b0;
            if (max_gap > 0)
                repeat ($unsigned($random(seed)) % (max_gap + 1)) next_cycle();
        end
    endtask

    // Redirect and arm the checker for n results from target
    task automatic begin_fetch(input logic [31:0] target, input int n);
        exp_pc         = target;
        got_n          = 0;
        expect_n       = n;
        redirect_valid = 1'b1;
        redirect_pc    = target;
        fetch_ready    = 1'b1;
        next_cycle();
        redirect_valid = 1'b0;
    endtask

    // Decode side stalls as soon as the last expected result is taken
    task automatic wait_results(input int limit, input bit stall);
        int cycles;
        cycles = 0;
        while (got_n < expect_n && cycles < limit) begin
            next_cycle();
            cycles++;
            if (stall && got_n < expect_n)
                fetch_ready = ($random(seed) & 32'h1) != 0;
        end
        fetch_ready = 1'b0;
        if (got_n < expect_n) begin
            errors++;
            $display("only %0d of %0d results arrived within %0d cycles", got_n, expect_n,
                     limit);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d results, %0d errors", tests_run, name, got_n,
                 errors - errors_at_start);
        errors_at_start = errors;
    endtask

    ////////////////////
    // Bus responder

    initial begin : bus_responder
        logic [31:0] addr;
        int          delay;
        ibus_req_ready  = 1'b0;
        ibus_resp_valid = 1'b0;
        ibus_resp_data  = 32'h0;
        forever begin
            next_cycle();
            if (ibus_req_valid === 1'b1) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) next_cycle();
                addr           = ibus_req_addr;
                ibus_req_ready = 1'b1;
                next_cycle();
                ibus_req_ready = 1'b0;
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) next_cycle();
                ibus_resp_data  = ref_bus_word(addr);
                ibus_resp_valid = 1'b1;
                next_cycle();
                ibus_resp_valid = 1'b0;
            end
        end
    end

    ////////////////////
    // Result checker

    // Sampled mid cycle, where the handshake for the next edge is settled
    initial begin : compare_results
        logic [32:0] want;
        hold_seen = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (fetch_valid && fetch_ready) begin
                    if (got_n >= expect_n) begin
                        errors++;
                        $display("unexpected result at %0t for pc %h after %0d expected",
                                 $time, fetch_pc, expect_n);
                    end else begin
                        want = ref_expect(exp_pc);
                        check_value("fetch_pc", fetch_pc, exp_pc);
                        check_value("fetch_fault", 32'(fetch_fault), 32'(want[32]));
                        check_value("fetch_instr", fetch_instr, want[31:0]);
                        got_n++;
                        exp_pc = exp_pc + 32'd4;
                    end
                end
                // A stalled result stays put until taken or flushed
                if (hold_seen && !redirect_valid) begin
                    check_value("fetch_valid", 32'(fetch_valid), 32'h1);
                    check_value("fetch_pc", fetch_pc, held_pc);
                    check_value("fetch_instr", fetch_instr, held_instr);
                end
                hold_seen  = fetch_valid && !fetch_ready;
                held_pc    = fetch_pc;
                held_instr = fetch_instr;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run stopped after %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    ////////////////////
    // Tests

    initial begin : run_tests
        seed            = 32'h210ab790;
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        errors_at_start = 0;
        got_n           = 0;
        expect_n        = 0;
        exp_pc          = RESET_PC;
        rst             = 1'b1;
        load_valid      = 1'b0;
        load_addr       = '0;
        load_data       = 32'h0;
        // Held on the reset vector so nothing issues before the RAM is loaded
        redirect_valid  = 1'b1;
        redirect_pc     = RESET_PC;
        fetch_ready     = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        if (fetch_valid !== 1'b0 || ibus_req_valid !== 1'b0) begin
            errors++;
            $display("fetch_valid or ibus_req_valid not low after reset at %0t", $time);
        end
        load_block(0, 64, 0);
        exp_pc         = RESET_PC;
        got_n          = 0;
        expect_n       = 64;
        redirect_valid = 1'b0;
        fetch_ready    = 1'b1;
        wait_results(64 * WAIT_PER_RESULT, 1'b0);
        finish_test("local fetch from reset vector");

        begin_fetch(32'h8000_0100, 32);
        wait_results(32 * WAIT_PER_RESULT, 1'b0);
        finish_test("bus fetch after redirect");

        // Fault, then silence until the next redirect
        begin_fetch(32'h4000_0000, 1);
        wait_results(WAIT_PER_RESULT, 1'b0);
        fetch_ready = 1'b1;
        repeat (20) begin
            next_cycle();
            if (fetch_valid !== 1'b0) begin
                errors++;
                $display("fetch_valid high at %0t after a fault with no redirect", $time);
            end
        end
        begin_fetch(32'h0000_0080, 8);
        wait_results(8 * WAIT_PER_RESULT, 1'b0);
        finish_test("unmapped fault and resume");

        begin_fetch(RESET_PC, 48);
        wait_results(48 * WAIT_PER_RESULT, 1'b1);
        finish_test("random decode stalls");

        // Loader targets words 512 and up while words 0 to 63 are fetched
        begin_fetch(RESET_PC, 64);
        fork
            wait_results(64 * WAIT_PER_RESULT, 1'b0);
            load_block(512, 64, 2);
        join
        begin_fetch(32'h0000_0800, 32);
        wait_results(32 * WAIT_PER_RESULT, 1'b0);
        finish_test("loader writes during fetch");

        // Alternating redirects with one issue cycle between them
        redirect_valid = 1'b1;
        redirect_pc    = 32'h8000_0200;
        next_cycle();
        redirect_valid = 1'b0;
        next_cycle();
        redirect_valid = 1'b1;
        redirect_pc    = 32'h0000_0080;
        next_cycle();
        redirect_valid = 1'b0;
        next_cycle();
        redirect_valid = 1'b1;
        redirect_pc    = 32'h8000_0300;
        next_cycle();
        redirect_valid = 1'b0;
        next_cycle();
        begin_fetch(32'h0000_0040, 16);
        wait_results(16 * WAIT_PER_RESULT, 1'b0);
        finish_test("back to back redirects");

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+verif
logic/fetch_pkg.sv
logic/fetch_ifs.sv
logic/attr_fifo.sv
logic/inst_ram.sv
logic/ram_arbiter.sv
logic/local_mem_unit.sv
logic/bus_unit.sv
logic/fetch_unit.sv
logic/fetch_top.sv
verif/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the fetch stage testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fetch_tb -f sources.f -o fetch_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
